// ==== src/pov_pkg.sv ====
`default_nettype none

package pov_pkg;

    // Display geometry
    localparam int MULTIPLEXING   = 8;
    localparam int LED_PER_DRIVER = 16;
    localparam int ROW_SIZE       = 80;
    localparam int COLUMN_SIZE    = 48;
    localparam int IMAGE_SIZE     = ROW_SIZE * COLUMN_SIZE;
    localparam int N_LANES        = 30;
    localparam int LANE_DEPTH     = MULTIPLEXING * LED_PER_DRIVER;
    localparam int POKER_MODE     = 9;

    // Bus widths and counter widths
    localparam int RAM_ADDR_W = 32;
    localparam int PIXEL_W    = 16;
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;
    localparam int BLANK_W    = 16;
    localparam int MUL_W      = $clog2(MULTIPLEXING);
    localparam int LED_W      = $clog2(LED_PER_DRIVER);
    localparam int SLOT_W     = $clog2(POKER_MODE);
    localparam int ROW_W      = $clog2(COLUMN_SIZE);
    localparam int COL_W      = $clog2(ROW_SIZE);

    // Two interleaved drivers per 16 pixel wide block, five blocks across
    localparam int LANES_PER_BAND = 2 * ROW_SIZE / LED_PER_DRIVER;

    localparam logic [BLANK_W-1:0] BLANK_DEFAULT = BLANK_W'(80);

    // APB register map
    localparam logic [APB_ADDR_W-1:0] REG_RAM_BASE  = 8'h0;
    localparam logic [APB_ADDR_W-1:0] REG_BLANK_LEN = 8'h4;
    localparam logic [APB_ADDR_W-1:0] REG_SLICE_CNT = 8'h8;

    // RGB565 with red on top and blue at the bottom
    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [4:0] lane_idx_t;
    typedef logic [6:0] lane_addr_t;

    // Drivers sit in bands of 16 rows, neighbours share a block column by column parity
    function automatic lane_idx_t lane_of(input logic [ROW_W-1:0] row,
                                          input logic [COL_W-1:0] col);
        return lane_idx_t'(int'(row[ROW_W-1:LED_W]) * LANES_PER_BAND
                           + int'(col[COL_W-1:LED_W]) * 2 + int'(col[0]));
    endfunction

    // LED row selects the group of 8, the column pair selects the multiplexed column
    function automatic lane_addr_t lane_addr_of(input logic [ROW_W-1:0] row,
                                                input logic [COL_W-1:0] col);
        return {row[LED_W-1:0], col[LED_W-1:1]};
    endfunction

    // Returns the pixel bit for a colour and slot, the top bit flags a padding slot
    // Green fills slots 8 to 3, red and blue only slots 8 to 4
    function automatic logic [4:0] slot_bit(input logic [1:0] rgb,
                                            input logic [SLOT_W-1:0] slot);
        if (rgb == 2'd1) begin
            return (slot >= SLOT_W'(3)) ? {1'b0, 4'(slot + 4'd2)} : 5'b10000;
        end
        if (slot < SLOT_W'(4)) begin
            return 5'b10000;
        end
        return (rgb == 2'd0) ? {1'b0, 4'(slot + 4'd7)} : {1'b0, 4'(slot - 4'd4)};
    endfunction

endpackage

`default_nettype wire

// ==== src/pov_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write port from the slice loader into the lane memories
interface pixel_wr_if;
    import pov_pkg::*;

    logic       valid;
    logic       bank;
    lane_idx_t  lane;
    lane_addr_t addr;
    pixel_t     pixel;

    // No back-pressure, every lane just watches for its own index
    modport loader (output valid, bank, lane, addr, pixel);
    modport target (input valid, bank, lane, addr, pixel);
endinterface

// Scan position broadcast by the sequencer
interface scan_if;
    import pov_pkg::*;

    logic              active;
    logic              show_bank;
    logic [MUL_W-1:0]  mul_idx;
    logic [LED_W-1:0]  led_idx;
    logic [1:0]        rgb_idx;
    logic [SLOT_W-1:0] bit_idx;
    logic              sync;

    modport source (
        output active, show_bank, mul_idx, led_idx, rgb_idx, bit_idx, sync
    );
    // Lanes only need the read position
    modport lane (input show_bank, mul_idx, led_idx, rgb_idx, bit_idx);
    // The collector only needs the framing
    modport collector (input active, sync);
endinterface

`default_nettype wire

// ==== src/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
    input  logic                             clk_33,
    input  logic                             nrst,
    input  logic [pov_pkg::APB_ADDR_W-1:0]   paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [pov_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [pov_pkg::APB_DATA_W-1:0]   prdata,
    output logic                             pready,
    output logic                             pslverr,
    input  logic                             load_done,
    output logic [pov_pkg::RAM_ADDR_W-1:0]   ram_base,
    output logic [pov_pkg::BLANK_W-1:0]      blank_len
);
    import pov_pkg::*;

    logic                  access;
    logic                  known;
    logic [APB_DATA_W-1:0] slice_cnt;

    // Zero wait states
    assign pready = 1'b1;
    assign access = psel && penable;
    assign known  = (paddr == REG_RAM_BASE) || (paddr == REG_BLANK_LEN)
                    || (paddr == REG_SLICE_CNT);

    // The slice counter is read only, so writing it is an error too
    assign pslverr = access && (!known || (pwrite && paddr == REG_SLICE_CNT));

    always_comb begin
        case (paddr)
            REG_RAM_BASE:  prdata = ram_base;
            REG_BLANK_LEN: prdata = APB_DATA_W'(blank_len);
            REG_SLICE_CNT: prdata = slice_cnt;
            default:       prdata = '0;
        endcase
    end

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            ram_base  <= '0;
            blank_len <= BLANK_DEFAULT;
            slice_cnt <= '0;
        end else begin
            if (access && pwrite && paddr == REG_RAM_BASE) begin
                ram_base <= pwdata;
            end
            if (access && pwrite && paddr == REG_BLANK_LEN) begin
                blank_len <= pwdata[BLANK_W-1:0];
            end
            // One count per slice fully copied into the framebuffer
            if (load_done) begin
                slice_cnt <= slice_cnt + 1'b1;
            end
        end
    end

    // A setup phase must be followed by its access phase on the same select
    assert property (@(posedge clk_33) disable iff (!nrst)
        psel && !penable |=> psel && penable);

endmodule

`default_nettype wire

// ==== src/slice_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module slice_loader (
    input  logic                           clk_33,
    input  logic                           nrst,
    input  logic [7:0]                     enc_position,
    input  logic                           enc_sync,
    input  logic [pov_pkg::RAM_ADDR_W-1:0] ram_base,
    output logic [pov_pkg::RAM_ADDR_W-1:0] ram_addr,
    input  pov_pkg::pixel_t                ram_data,
    output logic                           load_done,
    output logic                           load_bank,
    pixel_wr_if.loader                     wr
);
    import pov_pkg::*;

    // Issue stage, position of the word whose address is on the bus
    logic             issue;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic             last;
    // Write stage, one cycle later when the RAM answers
    logic             wr_valid;
    logic             wr_last;
    lane_idx_t        wr_lane;
    lane_addr_t       wr_addr;
    logic             done_seen;

    assign last = (row == ROW_W'(COLUMN_SIZE - 1)) && (col == COL_W'(ROW_SIZE - 1));

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            issue     <= 1'b0;
            load_bank <= 1'b0;
            ram_addr  <= '0;
            row       <= '0;
            col       <= '0;
        end else if (enc_sync) begin
            // A sync mid-load simply restarts into the other bank
            issue     <= 1'b1;
            load_bank <= ~load_bank;
            ram_addr  <= ram_base + RAM_ADDR_W'(enc_position) * RAM_ADDR_W'(IMAGE_SIZE);
            row       <= '0;
            col       <= '0;
        end else if (issue) begin
            ram_addr <= ram_addr + 1'b1;
            if (last) begin
                issue <= 1'b0;
            end
            if (col == COL_W'(ROW_SIZE - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // The word in flight at a restart belongs to the old slice and is dropped
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            wr_valid <= 1'b0;
            wr_last  <= 1'b0;
        end else begin
            wr_valid <= issue && !enc_sync;
            wr_last  <= issue && last && !enc_sync;
        end
    end

    // Lane position follows the address by one cycle like the RAM data does
    always_ff @(posedge clk_33) begin
        wr_lane <= lane_of(row, col);
        wr_addr <= lane_addr_of(row, col);
    end

    assign wr.valid  = wr_valid;
    assign wr.bank   = load_bank;
    assign wr.lane   = wr_lane;
    assign wr.addr   = wr_addr;
    assign wr.pixel  = ram_data;
    assign load_done = wr_last;

    // Tracks the idle gap between a finished load and the next encoder sync
    always_ff @(posedge clk_33) begin
        if (!nrst || enc_sync) begin
            done_seen <= 1'b0;
        end else if (load_done) begin
            done_seen <= 1'b1;
        end
    end

    // Once a slice is complete the lanes must not be written until a new sync
    assert property (@(posedge clk_33) disable iff (!nrst) done_seen |-> !wr.valid);

endmodule

`default_nettype wire

// ==== src/scan_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
    input  logic                        clk_33,
    input  logic                        nrst,
    input  logic [pov_pkg::BLANK_W-1:0] blank_len,
    input  logic                        load_bank,
    scan_if.source                      scan
);
    import pov_pkg::*;

    logic               blanking;
    logic [BLANK_W-1:0] blank_cnt;
    logic [MUL_W-1:0]   mul_idx;
    logic [LED_W-1:0]   led_idx;
    logic [1:0]         rgb_idx;
    logic [SLOT_W-1:0]  bit_idx;
    logic               frame_end;

    // Last colour of the last LED of slot 0 in column 7
    assign frame_end = (rgb_idx == 2'd2) && (led_idx == LED_W'(LED_PER_DRIVER - 1))
                       && (bit_idx == '0) && (mul_idx == MUL_W'(MULTIPLEXING - 1));

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            blanking  <= 1'b1;
            blank_cnt <= BLANK_DEFAULT - 1'b1;
            mul_idx   <= '0;
            led_idx   <= '0;
            rgb_idx   <= '0;
            bit_idx   <= SLOT_W'(POKER_MODE - 1);
        end else if (blanking) begin
            // The counters wait at the start of column 0 while blanking runs
            if (blank_cnt == '0) begin
                blanking <= 1'b0;
            end else begin
                blank_cnt <= blank_cnt - 1'b1;
            end
        end else begin
            rgb_idx <= (rgb_idx == 2'd2) ? 2'd0 : rgb_idx + 1'b1;
            if (rgb_idx == 2'd2) begin
                led_idx <= led_idx + 1'b1;
                if (led_idx == LED_W'(LED_PER_DRIVER - 1)) begin
                    // Poker mode sends the most significant slot first
                    bit_idx <= (bit_idx == '0) ? SLOT_W'(POKER_MODE - 1) : bit_idx - 1'b1;
                    if (bit_idx == '0) begin
                        mul_idx <= mul_idx + 1'b1;
                    end
                end
            end
            // Blanking length is sampled here and held to at least two cycles
            if (frame_end) begin
                blanking  <= 1'b1;
                blank_cnt <= (blank_len < BLANK_W'(2)) ? BLANK_W'(1) : blank_len - 1'b1;
            end
        end
    end

    assign scan.active    = !blanking;
    assign scan.show_bank = ~load_bank;
    assign scan.mul_idx   = mul_idx;
    assign scan.led_idx   = led_idx;
    assign scan.rgb_idx   = rgb_idx;
    assign scan.bit_idx   = bit_idx;
    // Last blanking cycle, so it reaches the port one cycle ahead of the first data word
    assign scan.sync      = blanking && (blank_cnt == '0);

    // Sync sits in blanking and is followed straight away by the start of column 0
    assert property (@(posedge clk_33) disable iff (!nrst)
        scan.sync |-> !scan.active ##1 (scan.active && mul_idx == '0 && led_idx == '0
            && rgb_idx == '0 && bit_idx == SLOT_W'(POKER_MODE - 1)));

endmodule

`default_nettype wire

// ==== src/driver_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_lane #(
    parameter int LANE = 0
) (
    input  logic       clk_33,
    pixel_wr_if.target wr,
    scan_if.lane       scan,
    output logic       lane_bit
);
    import pov_pkg::*;

    // Both banks in one array, the bank is the top address bit
    pixel_t     mem [2*LANE_DEPTH];
    logic [4:0] sel;
    logic       hit;

    assign hit = wr.valid && (wr.lane == lane_idx_t'(LANE));

    always_ff @(posedge clk_33) begin
        if (hit) begin
            mem[{wr.bank, wr.addr}] <= wr.pixel;
        end
    end

    // Pixel bit for the current colour and slot, top bit set on padding
    assign sel = slot_bit(scan.rgb_idx, scan.bit_idx);

    // Pixel led_idx*8+mul_idx from the bank on display, one cycle of read latency
    always_ff @(posedge clk_33) begin
        if (sel[4]) begin
            lane_bit <= 1'b0;
        end else begin
            lane_bit <= mem[{scan.show_bank, scan.led_idx, scan.mul_idx}][sel[3:0]];
        end
    end

endmodule

`default_nettype wire

// ==== src/lane_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_collector (
    input  logic                        clk_33,
    input  logic                        nrst,
    input  logic [pov_pkg::N_LANES-1:0] lane_bits,
    scan_if.collector                   scan,
    output logic [pov_pkg::N_LANES-1:0] data,
    output logic                        sync
);
    import pov_pkg::*;

    // Framing delayed to line up with the lane read latency
    logic active_d;
    logic sync_d;

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            active_d <= 1'b0;
            sync_d   <= 1'b0;
            data     <= '0;
            sync     <= 1'b0;
        end else begin
            active_d <= scan.active;
            sync_d   <= scan.sync;
            // Blanking cycles go out as all zero whatever the lanes hold
            data     <= active_d ? lane_bits : {N_LANES{1'b0}};
            sync     <= sync_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/pov_framebuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pov_framebuffer (
    input  logic                           clk_33,
    input  logic                           nrst,
    input  logic [pov_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [pov_pkg::APB_DATA_W-1:0] pwdata,
    output logic [pov_pkg::APB_DATA_W-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic [pov_pkg::RAM_ADDR_W-1:0] ram_addr,
    input  pov_pkg::pixel_t                ram_data,
    input  logic [7:0]                     enc_position,
    input  logic                           enc_sync,
    output logic [pov_pkg::N_LANES-1:0]    data,
    output logic                           sync
);
    import pov_pkg::*;

    logic [RAM_ADDR_W-1:0] ram_base;
    logic [BLANK_W-1:0]    blank_len;
    logic                  load_done;
    logic                  load_bank;
    logic [N_LANES-1:0]    lane_bits;

    pixel_wr_if wr ();
    scan_if     scan ();

    apb_regs u_regs (
        .clk_33    (clk_33),
        .nrst      (nrst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .load_done (load_done),
        .ram_base  (ram_base),
        .blank_len (blank_len)
    );

    slice_loader u_loader (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .enc_position (enc_position),
        .enc_sync     (enc_sync),
        .ram_base     (ram_base),
        .ram_addr     (ram_addr),
        .ram_data     (ram_data),
        .load_done    (load_done),
        .load_bank    (load_bank),
        .wr           (wr)
    );

    // Displays the bank the loader is not writing
    scan_sequencer u_seq (
        .clk_33    (clk_33),
        .nrst      (nrst),
        .blank_len (blank_len),
        .load_bank (load_bank),
        .scan      (scan)
    );

    // One lane per LED driver, each keeps its own slice of the image
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        driver_lane #(.LANE(g)) u_lane (
            .clk_33   (clk_33),
            .wr       (wr),
            .scan     (scan),
            .lane_bit (lane_bits[g])
        );
    end

    lane_collector u_coll (
        .clk_33    (clk_33),
        .nrst      (nrst),
        .lane_bits (lane_bits),
        .scan      (scan),
        .data      (data),
        .sync      (sync)
    );

endmodule

`default_nettype wire

// ==== verif/pov_ram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// External image RAM with one cycle of read latency
module pov_ram_model (
    input  wire logic        clk_33,
    input  wire logic [31:0] addr,
    output logic [15:0]      rdata
);

    // Every word is a hash of its full address, so a misplaced read shows up
    function automatic logic [15:0] scramble(input logic [31:0] a);
        logic [31:0] m;
        m = a * 32'h9E37_79B1;
        return m[31:16] ^ m[15:0];
    endfunction

    always @(posedge clk_33) begin
        rdata <= scramble(addr);
    end

endmodule

`default_nettype wire

// ==== verif/tb_pov.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pov;
    import pov_pkg::*;

    localparam int FRAME_DATA = 3 * LED_PER_DRIVER * POKER_MODE * MULTIPLEXING;
    localparam int BLANK_LONG = 200;
    // Two loads, three frames at the longest blanking and a margin
    localparam int WATCHDOG_CYCLES = 2 * (IMAGE_SIZE + 1) + 3 * (BLANK_LONG + FRAME_DATA) + 1000;

    logic        clk_33;
    logic        nrst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] ram_addr;
    logic [15:0] ram_data;
    logic [7:0]  enc_position;
    logic        enc_sync;
    logic [29:0] data;
    logic        sync;

    // Reference state, updated on the falling edge so it is stable at the rising edge
    logic [31:0] lfsr;
    logic [31:0] slice_base;
    logic [31:0] exp_addr;
    logic [29:0] exp_data;
    int          since_sync;
    int          last_period;
    int          syncs;
    int          exp_period;
    logic        addr_chk;
    logic        data_chk;
    logic        period_chk;
    int          addr_errs;
    int          data_errs;
    int          sync_errs;
    int          reg_errs;

    pov_framebuffer DUT (
        .clk_33(clk_33), .nrst(nrst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .ram_addr(ram_addr), .ram_data(ram_data),
        .enc_position(enc_position), .enc_sync(enc_sync), .data(data), .sync(sync)
    );

    pov_ram_model u_ram (.clk_33(clk_33), .addr(ram_addr), .rdata(ram_data));

    initial begin
        clk_33 = 1'b0;
        forever #5 clk_33 = ~clk_33;
    end

    // Same hash as the RAM holds, written out from the RAM description
    function automatic logic [15:0] ram_word(input logic [31:0] a);
        logic [31:0] m;
        m = a * 32'h9E37_79B1;
        return m[31:16] ^ m[15:0];
    endfunction

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [7:0] random_byte();
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int n = 0; n < 8; n++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[6:0], fb};
        end
        return v;
    endfunction

    // Green spans slots 8 to 3, red and blue slots 8 to 4, everything else is padding
    function automatic logic colour_bit(input logic [15:0] p, input int rgb, input int slot);
        if (rgb == 1) begin
            return (slot >= 3) ? p[5 + slot - 3] : 1'b0;
        end
        if (slot < 4) begin
            return 1'b0;
        end
        return (rgb == 0) ? p[11 + slot - 4] : p[slot - 4];
    endfunction

    // Word expected k cycles after the sync pulse, zero outside the 3456 data cycles
    function automatic logic [29:0] expected_word(input int k);
        logic [29:0] w;
        int          i;
        int          row;
        int          col;
        w = '0;
        if (k >= 1 && k <= FRAME_DATA) begin
            i = k - 1;
            for (int l = 0; l < 30; l++) begin
                row = (l / 10) * 16 + (i / 3) % 16;
                col = ((l % 10) / 2) * 16 + (i / 432) * 2 + l % 2;
                w[l] = colour_bit(ram_word(slice_base + 32'(row * ROW_SIZE + col)),
                                  i % 3, 8 - (i / 48) % 9);
            end
        end
        return w;
    endfunction

    always @(negedge clk_33) begin
        if (sync === 1'b1) begin
            last_period = since_sync + 1;
            since_sync = 0;
            syncs++;
        end else begin
            since_sync++;
        end
        exp_data = expected_word(since_sync);
    end

    assert property (@(posedge clk_33) addr_chk |-> ram_addr == exp_addr)
    else begin
        addr_errs++;
        $display("CHECK FAILED at %0t: ram_addr expected %h got %h",
                 $time, $sampled(exp_addr), $sampled(ram_addr));
    end

    // Covers the pixel bits, the padding slots and the blanking cycles alike
    assert property (@(posedge clk_33) data_chk |-> data == exp_data)
    else begin
        data_errs++;
        $display("CHECK FAILED at %0t: data expected %h got %h",
                 $time, $sampled(exp_data), $sampled(data));
    end

    assert property (@(posedge clk_33) period_chk && sync && syncs >= 2
                     |-> last_period == exp_period)
    else begin
        sync_errs++;
        $display("CHECK FAILED at %0t: sync period expected %0d got %0d",
                 $time, $sampled(exp_period), $sampled(last_period));
    end

    // No wait states, so every access phase completes at once
    assert property (@(posedge clk_33) psel && penable |-> pready)
    else begin
        reg_errs++;
        $display("CHECK FAILED at %0t: pready expected 1 got %b", $time, $sampled(pready));
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act)
        else begin
            reg_errs++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Setup and access phase, sampled just before the edge that ends the access
    task automatic apb_access(input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk_33);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_33);
        penable = 1'b1;
        #4;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_33);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp,
                            input logic exp_err, input string name);
        logic [31:0] rd;
        logic        err;
        apb_access(addr, 1'b0, '0, rd, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
        if (!exp_err) begin
            check_value(name, exp, rd);
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic exp_err, input string name);
        logic [31:0] rd;
        logic        err;
        apb_access(addr, 1'b1, wdata, rd, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    // Pulses the encoder and follows the address sweep word by word
    task automatic run_load(input logic [7:0] pos, input logic [31:0] base,
                            input logic [31:0] count_before);
        @(negedge clk_33);
        enc_position = pos;
        enc_sync     = 1'b1;
        @(negedge clk_33);
        enc_sync = 1'b0;
        exp_addr = base + 32'(pos) * 32'(IMAGE_SIZE);
        addr_chk = 1'b1;
        repeat (IMAGE_SIZE - 1) begin
            @(negedge clk_33);
            exp_addr = exp_addr + 1;
        end
        @(negedge clk_33);
        addr_chk = 1'b0;
        repeat (2) @(negedge clk_33);
        reg_read(REG_SLICE_CNT, count_before + 1, 1'b0, "slice_cnt");
    endtask

    task automatic wait_sync();
        @(negedge clk_33);
        while (sync !== 1'b1) begin
            @(negedge clk_33);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_33);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] base;
        logic [7:0]  pos1;
        logic [7:0]  pos2;
        nrst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        enc_position = '0;
        enc_sync = 1'b0;
        lfsr = 32'h4727;
        slice_base = '0;
        exp_addr = '0;
        exp_data = '0;
        since_sync = 0;
        last_period = 0;
        syncs = 0;
        exp_period = 80 + FRAME_DATA;
        addr_chk = 1'b0;
        data_chk = 1'b0;
        period_chk = 1'b0;
        addr_errs = 0;
        data_errs = 0;
        sync_errs = 0;
        reg_errs = 0;
        repeat (4) @(posedge clk_33);
        @(negedge clk_33);
        nrst = 1'b1;
        period_chk = 1'b1;

        // Reset values
        check_value("data", '0, 32'(data));
        check_value("sync", '0, 32'(sync));
        reg_read(REG_RAM_BASE, '0, 1'b0, "ram_base");
        reg_read(REG_BLANK_LEN, 32'd80, 1'b0, "blank_len");
        reg_read(REG_SLICE_CNT, '0, 1'b0, "slice_cnt");

        // Register access, all done inside the first blanking period
        base = 32'h0001_2000;
        reg_write(REG_RAM_BASE, base, 1'b0, "ram_base write");
        reg_read(REG_RAM_BASE, base, 1'b0, "ram_base");
        reg_write(REG_BLANK_LEN, 32'd120, 1'b0, "blank_len write");
        reg_read(REG_BLANK_LEN, 32'd120, 1'b0, "blank_len");
        reg_write(REG_BLANK_LEN, 32'd80, 1'b0, "blank_len write");
        reg_read(8'h0C, '0, 1'b1, "unknown read");
        reg_write(8'h10, 32'hFFFF_FFFF, 1'b1, "unknown write");
        reg_write(REG_SLICE_CNT, 32'h55, 1'b1, "slice_cnt write");
        reg_read(REG_SLICE_CNT, '0, 1'b0, "slice_cnt");

        // The second load flips the first slice onto the display bank
        pos1 = random_byte();
        pos2 = random_byte();
        slice_base = base + 32'(pos1) * 32'(IMAGE_SIZE);
        run_load(pos1, base, 32'd0);
        run_load(pos2, base, 32'd1);

        // One whole frame from a sync, then a longer blanking for the next one
        wait_sync();
        data_chk = 1'b1;
        reg_write(REG_BLANK_LEN, 32'(BLANK_LONG), 1'b0, "blank_len write");
        reg_read(REG_BLANK_LEN, 32'(BLANK_LONG), 1'b0, "blank_len");
        exp_period = BLANK_LONG + FRAME_DATA;
        wait_sync();
        repeat (2) @(negedge clk_33);

        $display("Errors: ram_addr %0d, data %0d, sync %0d, registers %0d",
                 addr_errs, data_errs, sync_errs, reg_errs);
        if (addr_errs + data_errs + sync_errs + reg_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/pov_pkg.sv
src/pov_if.sv
src/apb_regs.sv
src/slice_loader.sv
src/scan_sequencer.sv
src/driver_lane.sv
src/lane_collector.sv
src/pov_framebuffer.sv
verif/pov_ram_model.sv
verif/tb_pov.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pov -f src.f -o tb_pov
	./obj_dir/tb_pov | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
